/* include/z80_seq_params.svh */
`ifndef Z80_SEQ_PARAMS_SVH
`define Z80_SEQ_PARAMS_SVH

// Bus widths
`define Z80_ADDR_W 16
`define Z80_DATA_W 8

// T-states per machine cycle
`define Z80_M1_TSTATES 4
`define Z80_MEM_TSTATES 3

// Instruction state counter
`define Z80_STATE_W 2

`endif

/* src/z80_seq_pkg.sv */
`include "z80_seq_params.svh"

package z80_seq_pkg;

    typedef enum logic [1:0] {
        CYC_M1     = 2'd0,
        CYC_MEM_RD = 2'd1,
        CYC_MEM_WR = 2'd2
    } cycle_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_XOR = 2'd3
    } alu_func_e;

    typedef struct packed {
        logic zero;
        logic carry;
    } flags_t;

    // Where the byte of the current read cycle goes
    typedef enum logic [1:0] {
        CAP_NONE    = 2'd0,
        CAP_OP      = 2'd1,
        CAP_OPERAND = 2'd2
    } capture_e;

    // Everything applied at the end of the current machine cycle
    typedef struct packed {
        cycle_e                  next_cycle;
        logic [`Z80_ADDR_W-1:0]  next_addr;
        logic [`Z80_ADDR_W-1:0]  next_ip;
        logic [`Z80_STATE_W-1:0] next_state;
        logic                    acc_wr;
        logic                    acc_from_alu;
        logic                    flags_wr;
        logic                    done;
    } seq_ctrl_t;

    // Operand bytes are little-endian, first byte in the low half
    typedef struct packed {
        logic [`Z80_DATA_W-1:0]   opcode;
        logic [2*`Z80_DATA_W-1:0] operand;
        logic [1:0]               operand_len;
        logic                     opcode_valid;
    } insn_view_t;

endpackage

/* src/mcycle_timer.sv */
`timescale 1ns/1ps
`include "z80_seq_params.svh"

module mcycle_timer (
    input  logic                clk,
    input  logic                i_arst_n,
    input  z80_seq_pkg::cycle_e i_next_cycle,
    output z80_seq_pkg::cycle_e o_cycle,
    output logic                o_mcycle_done,
    output logic                o_first_tstate,
    output logic                o_mem_rd,
    output logic                o_mem_wr
);
    import z80_seq_pkg::*;

    localparam int TW = $clog2(`Z80_M1_TSTATES);

    logic [TW-1:0] tstate;
    logic [TW-1:0] last_tstate;

    // M1 is one clock longer than a plain memory cycle
    assign last_tstate = (o_cycle == CYC_M1) ? TW'(`Z80_M1_TSTATES - 1)
                                             : TW'(`Z80_MEM_TSTATES - 1);

    assign o_mcycle_done  = (tstate == last_tstate);
    assign o_first_tstate = (tstate == '0);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            tstate  <= '0;
            o_cycle <= CYC_M1;
        end else if (o_mcycle_done) begin
            tstate  <= '0;
            o_cycle <= i_next_cycle;
        end else begin
            tstate <= tstate + 1'b1;
        end
    end

    // Opcode fetch counts as a read
    assign o_mem_rd = (o_cycle != CYC_MEM_WR);
    assign o_mem_wr = (o_cycle == CYC_MEM_WR);

    // Only a defined cycle type may be loaded at the end of a cycle
    a_next_cycle_legal: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        o_mcycle_done |-> (i_next_cycle inside {CYC_M1, CYC_MEM_RD, CYC_MEM_WR}));

endmodule

/* src/insn_collector.sv */
`timescale 1ns/1ps
`include "z80_seq_params.svh"

module insn_collector (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_mcycle_done,
    input  z80_seq_pkg::capture_e   i_capture,
    input  logic                    i_done,
    input  logic [`Z80_DATA_W-1:0]  i_bus_rdata,
    output z80_seq_pkg::insn_view_t o_view
);
    import z80_seq_pkg::*;

    insn_view_t view_q;

    // Bus byte shows up in the view on the clock it is captured
    always_comb begin
        o_view = view_q;
        if (i_mcycle_done) begin
            case (i_capture)
                CAP_OP: begin
                    o_view.opcode       = i_bus_rdata;
                    o_view.opcode_valid = 1'b1;
                end
                CAP_OPERAND: begin
                    // Little-endian: first operand byte is the low one
                    if (view_q.operand_len == 2'd0) begin
                        o_view.operand = {view_q.operand[2*`Z80_DATA_W-1:`Z80_DATA_W],
                                          i_bus_rdata};
                    end else begin
                        o_view.operand = {i_bus_rdata,
                                          view_q.operand[`Z80_DATA_W-1:0]};
                    end
                    o_view.operand_len = view_q.operand_len + 2'd1;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            view_q <= '0;
        end else if (i_mcycle_done) begin
            if (i_done) begin
                view_q <= '0;
            end else begin
                view_q <= o_view;
            end
        end
    end

    // Decoder must stop asking for bytes after the second operand
    a_operand_len: assert property (
        @(posedge clk) disable iff (!i_arst_n) view_q.operand_len <= 2'd2);

endmodule

/* src/seq_decoder.sv */
`timescale 1ns/1ps
`include "z80_seq_params.svh"

module seq_decoder (
    input  z80_seq_pkg::insn_view_t  i_view,
    input  logic [`Z80_STATE_W-1:0]  i_state,
    input  logic [`Z80_ADDR_W-1:0]   i_ip,
    input  logic [`Z80_DATA_W-1:0]   i_acc,
    input  z80_seq_pkg::flags_t      i_flags,
    input  logic [`Z80_DATA_W-1:0]   i_alu_result,
    input  z80_seq_pkg::flags_t      i_alu_flags,
    output z80_seq_pkg::seq_ctrl_t   o_ctrl,
    output z80_seq_pkg::capture_e    o_capture,
    output z80_seq_pkg::alu_func_e   o_alu_func,
    output logic [`Z80_DATA_W-1:0]   o_wdata
);
    import z80_seq_pkg::*;

    localparam logic [`Z80_STATE_W-1:0] ST_FETCH   = 'd0;
    localparam logic [`Z80_STATE_W-1:0] ST_OPERAND = 'd1;
    localparam logic [`Z80_STATE_W-1:0] ST_WRITE   = 'd2;

    localparam logic [7:0] OP_LD_A_N  = 8'h3E;
    localparam logic [7:0] OP_ADD_N   = 8'hC6;
    localparam logic [7:0] OP_SUB_N   = 8'hD6;
    localparam logic [7:0] OP_AND_N   = 8'hE6;
    localparam logic [7:0] OP_XOR_N   = 8'hEE;
    localparam logic [7:0] OP_LD_NN_A = 8'h32;
    localparam logic [7:0] OP_JP      = 8'hC3;
    localparam logic [7:0] OP_JP_Z    = 8'hCA;
    localparam logic [7:0] OP_JP_C    = 8'hDA;

    logic [7:0]             opcode;
    logic [1:0]             need;
    logic                   is_alu_op;
    logic                   take_jump;
    logic [`Z80_ADDR_W-1:0] ip_inc;

    assign opcode = i_view.opcode;
    assign ip_inc = i_ip + 1'b1;

    // Operand count and ALU op per opcode; unknown opcodes act as NOP
    always_comb begin
        need       = 2'd0;
        is_alu_op  = 1'b0;
        o_alu_func = ALU_ADD;
        if (i_view.opcode_valid) begin
            case (opcode)
                OP_LD_A_N: need = 2'd1;
                OP_ADD_N: begin
                    need      = 2'd1;
                    is_alu_op = 1'b1;
                end
                OP_SUB_N: begin
                    need       = 2'd1;
                    is_alu_op  = 1'b1;
                    o_alu_func = ALU_SUB;
                end
                OP_AND_N: begin
                    need       = 2'd1;
                    is_alu_op  = 1'b1;
                    o_alu_func = ALU_AND;
                end
                OP_XOR_N: begin
                    need       = 2'd1;
                    is_alu_op  = 1'b1;
                    o_alu_func = ALU_XOR;
                end
                OP_LD_NN_A, OP_JP, OP_JP_Z, OP_JP_C: need = 2'd2;
                default: need = 2'd0;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            OP_JP:   take_jump = 1'b1;
            OP_JP_Z: take_jump = i_flags.zero;
            OP_JP_C: take_jump = i_flags.carry;
            default: take_jump = 1'b0;
        endcase
    end

    always_comb begin
        o_ctrl            = '0;
        o_ctrl.next_cycle = CYC_M1;
        o_ctrl.next_ip    = ip_inc;
        o_ctrl.next_addr  = ip_inc;
        o_ctrl.next_state = ST_FETCH;
        o_capture         = CAP_NONE;
        case (i_state)
            ST_FETCH: begin
                o_capture = CAP_OP;
                if (need == 2'd0) begin
                    o_ctrl.done = 1'b1;
                end else begin
                    o_ctrl.next_cycle = CYC_MEM_RD;
                    o_ctrl.next_state = ST_OPERAND;
                end
            end
            ST_OPERAND: begin
                o_capture = CAP_OPERAND;
                if (i_view.operand_len != need) begin
                    o_ctrl.next_cycle = CYC_MEM_RD;
                    o_ctrl.next_state = ST_OPERAND;
                end else if (opcode == OP_LD_NN_A) begin
                    // IP already points past the instruction
                    o_ctrl.next_cycle = CYC_MEM_WR;
                    o_ctrl.next_addr  = i_view.operand;
                    o_ctrl.next_state = ST_WRITE;
                end else begin
                    o_ctrl.done = 1'b1;
                    if (take_jump) begin
                        o_ctrl.next_ip   = i_view.operand;
                        o_ctrl.next_addr = i_view.operand;
                    end
                    // Skip register updates that leave the value unchanged
                    o_ctrl.acc_wr       = (opcode == OP_LD_A_N) ||
                                          (is_alu_op && (i_alu_result != i_acc));
                    o_ctrl.acc_from_alu = is_alu_op;
                    o_ctrl.flags_wr     = is_alu_op && (i_alu_flags != i_flags);
                end
            end
            default: begin
                // Write cycle ends the instruction, fetch resumes at IP
                o_ctrl.done      = 1'b1;
                o_ctrl.next_ip   = i_ip;
                o_ctrl.next_addr = i_ip;
            end
        endcase
    end

    assign o_wdata = i_acc;

endmodule

/* src/alu8.sv */
`timescale 1ns/1ps
`include "z80_seq_params.svh"

module alu8 (
    input  logic [`Z80_DATA_W-1:0] i_x,
    input  logic [`Z80_DATA_W-1:0] i_y,
    input  z80_seq_pkg::alu_func_e i_func,
    output logic [`Z80_DATA_W-1:0] o_result,
    output z80_seq_pkg::flags_t    o_flags
);
    import z80_seq_pkg::*;

    // One extra bit holds carry out or borrow
    logic [`Z80_DATA_W:0] wide;

    always_comb begin
        case (i_func)
            ALU_ADD: wide = {1'b0, i_x} + {1'b0, i_y};
            ALU_SUB: wide = {1'b0, i_x} - {1'b0, i_y};
            ALU_AND: wide = {1'b0, i_x & i_y};
            default: wide = {1'b0, i_x ^ i_y};
        endcase
    end

    assign o_result      = wide[`Z80_DATA_W-1:0];
    assign o_flags.carry = wide[`Z80_DATA_W];
    assign o_flags.zero  = (o_result == '0);

endmodule

/* src/seq_state.sv */
`timescale 1ns/1ps
`include "z80_seq_params.svh"

module seq_state (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_mcycle_done,
    input  z80_seq_pkg::seq_ctrl_t  i_ctrl,
    input  logic [`Z80_DATA_W-1:0]  i_alu_result,
    input  z80_seq_pkg::flags_t     i_alu_flags,
    input  logic [`Z80_DATA_W-1:0]  i_operand_lo,
    input  logic [`Z80_DATA_W-1:0]  i_wdata,
    output logic [`Z80_ADDR_W-1:0]  o_ip,
    output logic [`Z80_ADDR_W-1:0]  o_addr,
    output logic [`Z80_STATE_W-1:0] o_state,
    output logic [`Z80_DATA_W-1:0]  o_acc,
    output z80_seq_pkg::flags_t     o_flags,
    output logic [`Z80_DATA_W-1:0]  o_bus_wdata
);
    import z80_seq_pkg::*;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ip        <= '0;
            o_addr      <= '0;
            o_state     <= '0;
            o_acc       <= '0;
            o_flags     <= '0;
            o_bus_wdata <= '0;
        end else if (i_mcycle_done) begin
            o_ip    <= i_ctrl.next_ip;
            o_addr  <= i_ctrl.next_addr;
            o_state <= i_ctrl.next_state;

            // LD A,n takes the operand directly, ALU ops take the result
            if (i_ctrl.acc_wr) begin
                o_acc <= i_ctrl.acc_from_alu ? i_alu_result : i_operand_lo;
            end
            if (i_ctrl.flags_wr) begin
                o_flags <= i_alu_flags;
            end

            // Data bus is quiet outside write cycles
            if (i_ctrl.next_cycle == CYC_MEM_WR) begin
                o_bus_wdata <= i_wdata;
            end else begin
                o_bus_wdata <= '0;
            end
        end
    end

    // A finished instruction always hands over to a fetch at the new IP
    a_done_fetch_at_ip: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (i_mcycle_done && i_ctrl.done) |->
            (i_ctrl.next_addr == i_ctrl.next_ip) && (i_ctrl.next_cycle == CYC_M1));

endmodule

/* src/z80_seq.sv */
`timescale 1ns/1ps
`include "z80_seq_params.svh"

module z80_seq (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic [`Z80_DATA_W-1:0] i_bus_rdata,
    output logic [`Z80_ADDR_W-1:0] o_addr,
    output logic                   o_mem_rd,
    output logic                   o_mem_wr,
    output logic [`Z80_DATA_W-1:0] o_bus_wdata,
    output logic                   o_opcode_fetch,
    output logic                   o_done
);
    import z80_seq_pkg::*;

    cycle_e                  cycle;
    logic                    mcycle_done;
    logic                    first_tstate;
    insn_view_t              view;
    capture_e                capture;
    seq_ctrl_t               ctrl;
    alu_func_e               alu_func;
    logic [`Z80_DATA_W-1:0]  alu_result;
    flags_t                  alu_flags;
    logic [`Z80_ADDR_W-1:0]  ip;
    logic [`Z80_STATE_W-1:0] state;
    logic [`Z80_DATA_W-1:0]  acc;
    flags_t                  flags;
    logic [`Z80_DATA_W-1:0]  wdata;

    mcycle_timer timer_i (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_next_cycle   (ctrl.next_cycle),
        .o_cycle        (cycle),
        .o_mcycle_done  (mcycle_done),
        .o_first_tstate (first_tstate),
        .o_mem_rd       (o_mem_rd),
        .o_mem_wr       (o_mem_wr)
    );

    insn_collector collector_i (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_mcycle_done (mcycle_done),
        .i_capture     (capture),
        .i_done        (ctrl.done),
        .i_bus_rdata   (i_bus_rdata),
        .o_view        (view)
    );

    seq_decoder decoder_i (
        .i_view       (view),
        .i_state      (state),
        .i_ip         (ip),
        .i_acc        (acc),
        .i_flags      (flags),
        .i_alu_result (alu_result),
        .i_alu_flags  (alu_flags),
        .o_ctrl       (ctrl),
        .o_capture    (capture),
        .o_alu_func   (alu_func),
        .o_wdata      (wdata)
    );

    // Second ALU input is always the immediate operand
    alu8 alu_i (
        .i_x      (acc),
        .i_y      (view.operand[`Z80_DATA_W-1:0]),
        .i_func   (alu_func),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    seq_state state_i (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_mcycle_done (mcycle_done),
        .i_ctrl        (ctrl),
        .i_alu_result  (alu_result),
        .i_alu_flags   (alu_flags),
        .i_operand_lo  (view.operand[`Z80_DATA_W-1:0]),
        .i_wdata       (wdata),
        .o_ip          (ip),
        .o_addr        (o_addr),
        .o_state       (state),
        .o_acc         (acc),
        .o_flags       (flags),
        .o_bus_wdata   (o_bus_wdata)
    );

    assign o_opcode_fetch = first_tstate && (cycle == CYC_M1);
    assign o_done         = ctrl.done && mcycle_done;

endmodule

/* tests/z80_seq_tb.sv */
`timescale 1ns/1ps
`include "z80_seq_params.svh"

module z80_seq_tb;

    localparam int NUM_ROWS   = 25;
    localparam int MAX_CLOCKS = 32;
    localparam int SEED       = 32'h4d8a_4637;

    // Where the immediate byte of a one-operand instruction comes from
    localparam logic [1:0] OPD_NONE = 2'd0;
    localparam logic [1:0] OPD_FIX  = 2'd1;
    localparam logic [1:0] OPD_RAND = 2'd2;
    localparam logic [1:0] OPD_ACC  = 2'd3;

    typedef struct packed {
        logic [7:0] opcode;
        logic [1:0] src;
        logic [7:0] imm;
        logic [7:0] clocks;
    } row_t;

    logic                   clk         = 1'b0;
    logic                   i_arst_n    = 1'b0;
    logic [`Z80_DATA_W-1:0] i_bus_rdata = '0;
    logic [`Z80_ADDR_W-1:0] o_addr;
    logic                   o_mem_rd;
    logic                   o_mem_wr;
    logic [`Z80_DATA_W-1:0] o_bus_wdata;
    logic                   o_opcode_fetch;
    logic                   o_done;

    logic [7:0]  mem [0:65535];
    row_t        rows [0:NUM_ROWS-1];
    logic [15:0] exp_addr [0:NUM_ROWS];
    logic        exp_wr [0:NUM_ROWS-1];
    logic [15:0] exp_wr_addr [0:NUM_ROWS-1];
    logic [7:0]  exp_wr_data [0:NUM_ROWS-1];
    int          errors = 0;

    z80_seq dut_i (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_bus_rdata    (i_bus_rdata),
        .o_addr         (o_addr),
        .o_mem_rd       (o_mem_rd),
        .o_mem_wr       (o_mem_wr),
        .o_bus_wdata    (o_bus_wdata),
        .o_opcode_fetch (o_opcode_fetch),
        .o_done         (o_done)
    );

    always #2 clk = ~clk;

    // Memory model, read data follows the cycle address
    always @(negedge clk) begin
        i_bus_rdata <= mem[o_addr];
        // Store lands on the last clock of the write cycle
        if (o_mem_wr && o_done) begin
            mem[o_addr] = o_bus_wdata;
        end
    end

    task automatic flag_error(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errors++;
    endtask

    // Reference ALU, returns {zero, carry, result}
    function automatic logic [9:0] alu_model(input logic [7:0] op, input logic [7:0] a,
                                             input logic [7:0] n);
        logic [8:0] sum;
        logic [7:0] r;
        logic       cy;
        sum = {1'b0, a} + {1'b0, n};
        cy  = 1'b0;
        case (op)
            8'hC6: begin
                r  = sum[7:0];
                cy = sum[8];
            end
            8'hD6: begin
                r  = a - n;
                cy = (n > a);
            end
            8'hE6: r = a & n;
            default: r = a ^ n;
        endcase
        return {(r == 8'd0), cy, r};
    endfunction

    task automatic fill_memory();
        logic [15:0] a16;
        for (int a = 0; a < 65536; a++) begin
            a16 = a[15:0];
            mem[a16] = a16[15:8] ^ a16[7:0] ^ 8'h5A;
        end
    endtask

    // Opcode, operand source, fixed operand, expected clocks
    task automatic load_table();
        rows[0]  = '{8'h00, OPD_NONE, 8'h00, 8'd4};
        rows[1]  = '{8'h3E, OPD_RAND, 8'h00, 8'd7};
        rows[2]  = '{8'hC6, OPD_RAND, 8'h00, 8'd7};
        rows[3]  = '{8'h32, OPD_NONE, 8'h00, 8'd13};
        rows[4]  = '{8'h3E, OPD_RAND, 8'h00, 8'd7};
        rows[5]  = '{8'hD6, OPD_RAND, 8'h00, 8'd7};
        rows[6]  = '{8'h32, OPD_NONE, 8'h00, 8'd13};
        rows[7]  = '{8'h3E, OPD_RAND, 8'h00, 8'd7};
        rows[8]  = '{8'hE6, OPD_RAND, 8'h00, 8'd7};
        rows[9]  = '{8'h32, OPD_NONE, 8'h00, 8'd13};
        rows[10] = '{8'h3E, OPD_RAND, 8'h00, 8'd7};
        rows[11] = '{8'hEE, OPD_RAND, 8'h00, 8'd7};
        rows[12] = '{8'h32, OPD_NONE, 8'h00, 8'd13};
        rows[13] = '{8'hC3, OPD_NONE, 8'h00, 8'd10};
        rows[14] = '{8'h3E, OPD_RAND, 8'h00, 8'd7};
        // A minus itself sets zero and clears carry
        rows[15] = '{8'hD6, OPD_ACC,  8'h00, 8'd7};
        rows[16] = '{8'hCA, OPD_NONE, 8'h00, 8'd10};
        rows[17] = '{8'hDA, OPD_NONE, 8'h00, 8'd10};
        // 10h minus 11h borrows and leaves a nonzero result
        rows[18] = '{8'h3E, OPD_FIX,  8'h10, 8'd7};
        rows[19] = '{8'hD6, OPD_FIX,  8'h11, 8'd7};
        rows[20] = '{8'hDA, OPD_NONE, 8'h00, 8'd10};
        rows[21] = '{8'hCA, OPD_NONE, 8'h00, 8'd10};
        rows[22] = '{8'h76, OPD_NONE, 8'h00, 8'd4};
        rows[23] = '{8'hFF, OPD_NONE, 8'h00, 8'd4};
        rows[24] = '{8'hED, OPD_NONE, 8'h00, 8'd4};
    endtask

    // Walks the table with the model, places code and records expectations
    task automatic plan_program();
        logic [15:0] pc;
        logic [15:0] nn;
        logic [7:0]  op;
        logic [7:0]  acc;
        logic [7:0]  n;
        logic [9:0]  res;
        logic [31:0] rnd;
        logic        zf;
        logic        cf;
        logic        taken;
        pc  = '0;
        acc = '0;
        zf  = 1'b0;
        cf  = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            op             = rows[i].opcode;
            rnd            = $urandom;
            exp_addr[i]    = pc;
            exp_wr[i]      = 1'b0;
            exp_wr_addr[i] = '0;
            exp_wr_data[i] = '0;
            mem[pc]        = op;
            case (op)
                8'h3E, 8'hC6, 8'hD6, 8'hE6, 8'hEE: begin
                    case (rows[i].src)
                        OPD_RAND: n = rnd[7:0];
                        OPD_ACC:  n = acc;
                        default:  n = rows[i].imm;
                    endcase
                    mem[pc + 16'd1] = n;
                    if (op == 8'h3E) begin
                        acc = n;
                    end else begin
                        res = alu_model(op, acc, n);
                        zf  = res[9];
                        cf  = res[8];
                        acc = res[7:0];
                    end
                    pc = pc + 16'd2;
                end
                8'h32: begin
                    // Stores go to the upper half, code stays low
                    nn              = {1'b1, rnd[14:0]};
                    mem[pc + 16'd1] = nn[7:0];
                    mem[pc + 16'd2] = nn[15:8];
                    exp_wr[i]       = 1'b1;
                    exp_wr_addr[i]  = nn;
                    exp_wr_data[i]  = acc;
                    pc = pc + 16'd3;
                end
                8'hC3, 8'hCA, 8'hDA: begin
                    nn              = pc + 16'h0100;
                    mem[pc + 16'd1] = nn[7:0];
                    mem[pc + 16'd2] = nn[15:8];
                    taken = (op == 8'hC3) || (op == 8'hCA && zf) || (op == 8'hDA && cf);
                    pc = taken ? nn : pc + 16'd3;
                end
                default: pc = pc + 16'd1;
            endcase
        end
        exp_addr[NUM_ROWS] = pc;
    endtask

    task automatic wait_for_fetch(output logic seen);
        int n;
        n = 0;
        while (o_opcode_fetch !== 1'b1 && n < MAX_CLOCKS) begin
            @(negedge clk);
            n++;
        end
        seen = (o_opcode_fetch === 1'b1);
    endtask

    // Runs one instruction from its fetch up to the next fetch
    task automatic run_row(input int i, output logic hung);
        int clocks;
        int dones;
        int done_at;
        int wr_clocks;
        clocks    = 0;
        dones     = 0;
        done_at   = 0;
        wr_clocks = 0;
        if (o_addr !== exp_addr[i]) begin
            flag_error($sformatf("row %0d fetch at %h, expected %h", i, o_addr, exp_addr[i]));
        end
        do begin
            clocks++;
            if (o_done === 1'b1) begin
                dones++;
                done_at = clocks;
            end
            if (o_mem_rd === o_mem_wr) begin
                flag_error($sformatf("row %0d read and write strobes both %b", i, o_mem_rd));
            end
            if (o_mem_wr === 1'b1) begin
                wr_clocks++;
                if (!exp_wr[i]) begin
                    flag_error($sformatf("row %0d unexpected write to %h", i, o_addr));
                end else if (o_addr !== exp_wr_addr[i] || o_bus_wdata !== exp_wr_data[i]) begin
                    flag_error($sformatf("row %0d write %h to %h, expected %h to %h", i,
                                         o_bus_wdata, o_addr, exp_wr_data[i], exp_wr_addr[i]));
                end
            end else if (o_bus_wdata !== 8'h00) begin
                flag_error($sformatf("row %0d write data %h outside a write", i, o_bus_wdata));
            end
            @(negedge clk);
        end while (o_opcode_fetch !== 1'b1 && clocks < MAX_CLOCKS);
        hung = (o_opcode_fetch !== 1'b1);
        if (!hung) begin
            if (clocks != int'(rows[i].clocks)) begin
                flag_error($sformatf("row %0d took %0d clocks, expected %0d", i, clocks,
                                     rows[i].clocks));
            end
            if (dones != 1 || done_at != clocks) begin
                flag_error($sformatf("row %0d done seen %0d times, last at clock %0d",
                                     i, dones, done_at));
            end
            if (wr_clocks != (exp_wr[i] ? `Z80_MEM_TSTATES : 0)) begin
                flag_error($sformatf("row %0d write strobe for %0d clocks", i, wr_clocks));
            end
            if (exp_wr[i] && mem[exp_wr_addr[i]] !== exp_wr_data[i]) begin
                flag_error($sformatf("row %0d memory at %h holds %h, expected %h", i,
                                     exp_wr_addr[i], mem[exp_wr_addr[i]], exp_wr_data[i]));
            end
        end
    endtask

    initial begin
        logic        seen;
        logic        hung;
        int          errs_before;
        int          rows_ok;
        int          rows_bad;
        void'($urandom(SEED));
        rows_ok  = 0;
        rows_bad = 0;
        hung     = 1'b0;
        fill_memory();
        load_table();
        plan_program();

        repeat (8) begin
            @(negedge clk);
            if (o_mem_wr !== 1'b0 || o_done !== 1'b0 || o_bus_wdata !== 8'h00) begin
                flag_error("write strobe, done or write data active in reset");
            end
            if (o_mem_rd !== 1'b1) begin
                flag_error("read strobe low in reset");
            end
        end
        i_arst_n = 1'b1;

        wait_for_fetch(seen);
        if (!seen) begin
            $display("Timeout: no opcode fetch after reset was released");
            hung = 1'b1;
        end
        for (int i = 0; i < NUM_ROWS && !hung; i++) begin
            errs_before = errors;
            run_row(i, hung);
            if (hung) begin
                $display("Timeout: row %0d never reached the next opcode fetch", i);
            end else if (errors == errs_before) begin
                rows_ok++;
                $display("Row %0d opcode %h: ok", i, rows[i].opcode);
            end else begin
                rows_bad++;
                $display("Row %0d opcode %h: mismatch", i, rows[i].opcode);
            end
        end
        if (!hung && o_addr !== exp_addr[NUM_ROWS]) begin
            flag_error($sformatf("final fetch at %h, expected %h", o_addr, exp_addr[NUM_ROWS]));
        end

        $display("Rows passed %0d, rows failed %0d, failed checks %0d", rows_ok, rows_bad, errors);
        if (errors == 0 && !hung) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* z80_seq.f */
+incdir+include
src/z80_seq_pkg.sv
src/mcycle_timer.sv
src/insn_collector.sv
src/seq_decoder.sv
src/alu8.sv
src/seq_state.sv
src/z80_seq.sv
tests/z80_seq_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the z80_seq testbench, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f z80_seq.f --top-module z80_seq_tb -o z80_seq_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/z80_seq_sim > sim.log 2>&1 \
    && cat sim.log \
    || { cat sim.log; echo "Simulation exited with an error"; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
echo "Simulation log is clean"
exit 0
